// ==== logic/upsample_consts.svh ====
`ifndef UPSAMPLE_CONSTS_SVH
`define UPSAMPLE_CONSTS_SVH

// register map
`define UPS_REGS_N 9
`define UPS_REG_AW 4

// interrupt pulse length in cycles
`define UPS_ITR_PULSE_W 10

// pixel and row buffer
`define UPS_PIX_W 8
`define UPS_MAX_W 64
`define UPS_COL_W 6

// stream credits
`define UPS_IN_CREDITS 4
`define UPS_OUT_CREDITS 4

`endif

// ==== logic/upsample_pkg.sv ====
`default_nettype none

`include "upsample_consts.svh"

package upsample_pkg;

	typedef logic [31:0] word_t; // axi-lite data and register word
	typedef logic [`UPS_REG_AW-1:0] reg_ofs_t; // register word offset
	typedef logic [15:0] dim_t; // dimension, stored minus one
	typedef logic [`UPS_PIX_W-1:0] pix_t;
	typedef logic [`UPS_COL_W-1:0] col_t; // row buffer index

	// access phases of the register slave
	typedef enum logic [1:0] {
		ADDR,
		RW,
		RESP
	} reg_cfg_state_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD, // fill row buffer
		EMIT, // two passes over the row
		NEXT
	} ups_state_t;

endpackage

`default_nettype wire

// ==== logic/upsample_reg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "upsample_consts.svh"

module upsample_reg_if (
	input wire clk,
	input wire rst_n,
	input wire upsample_pkg::word_t s_axi_lite_araddr,
	input wire [2:0] s_axi_lite_arprot, // ignored
	input wire s_axi_lite_arvalid,
	output logic s_axi_lite_arready,
	input wire upsample_pkg::word_t s_axi_lite_awaddr,
	input wire [2:0] s_axi_lite_awprot, // ignored
	input wire s_axi_lite_awvalid,
	output logic s_axi_lite_awready,
	output logic [1:0] s_axi_lite_bresp,
	output logic s_axi_lite_bvalid,
	input wire s_axi_lite_bready,
	output upsample_pkg::word_t s_axi_lite_rdata,
	output logic [1:0] s_axi_lite_rresp,
	output logic s_axi_lite_rvalid,
	input wire s_axi_lite_rready,
	input wire upsample_pkg::word_t s_axi_lite_wdata,
	input wire [3:0] s_axi_lite_wstrb,
	input wire s_axi_lite_wvalid,
	output logic s_axi_lite_wready,
	output logic dma_mm2s_start,
	output logic dma_s2mm_start,
	input wire dma_mm2s_idle,
	input wire dma_s2mm_idle,
	input wire dma_mm2s_done,
	input wire dma_s2mm_done,
	output upsample_pkg::word_t in_ft_map_buf_baseaddr,
	output upsample_pkg::word_t in_ft_map_buf_len,
	output upsample_pkg::word_t out_ft_map_buf_baseaddr,
	output upsample_pkg::word_t out_ft_map_buf_len,
	output upsample_pkg::dim_t feature_map_chn_n,
	output upsample_pkg::dim_t feature_map_w,
	output upsample_pkg::dim_t feature_map_h,
	output logic itr_req
);
	import upsample_pkg::*;

	// byte-wise update of a register word
	function automatic word_t strb_merge(input word_t old_w, input word_t new_w,
		input logic [3:0] strb);
		word_t res;
		int b;
		res = old_w;
		for (b = 0; b < 4; b++)
		begin
			if (strb[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	reg_cfg_state_t cfg_state;
	logic is_write;
	reg_ofs_t ofs;
	logic wr_en;
	logic rd_en;
	word_t rd_mux;

	word_t buf_word [4]; // offsets 0x04 to 0x10
	word_t dim_word; // {w, chn_n}
	dim_t h_reg;
	logic mm2s_idle_r;
	logic s2mm_idle_r;
	logic glb_en;
	logic [1:0] itr_en_vec; // {s2mm, mm2s}
	logic glb_flag;
	logic [1:0] cause;
	logic [1:0] hit_vec;
	logic itr_req_now;
	logic flag_clr;

	assign s_axi_lite_bresp = 2'b00;
	assign s_axi_lite_rresp = 2'b00;

	// writes to offsets past the map are dropped
	assign wr_en = (cfg_state == RW) & is_write & s_axi_lite_wvalid & s_axi_lite_wready &
		(ofs < reg_ofs_t'(`UPS_REGS_N));
	assign rd_en = (cfg_state == RW) & ~is_write;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cfg_state <= ADDR;
		else
		begin
			case (cfg_state)
				ADDR:
					if (s_axi_lite_awvalid | s_axi_lite_arvalid)
						cfg_state <= RW;
				RW:
					if (~is_write | s_axi_lite_wvalid)
						cfg_state <= RESP;
				RESP:
					if (is_write ? s_axi_lite_bready : s_axi_lite_rready)
						cfg_state <= ADDR;
				default:
					cfg_state <= ADDR;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s_axi_lite_awready <= 1'b0;
			s_axi_lite_arready <= 1'b0;
			s_axi_lite_wready <= 1'b0;
			s_axi_lite_bvalid <= 1'b0;
			s_axi_lite_rvalid <= 1'b0;
			is_write <= 1'b0;
		end
		else
		begin
			// write wins when both address channels are valid
			s_axi_lite_awready <= (cfg_state == ADDR) & s_axi_lite_awvalid;
			s_axi_lite_arready <= (cfg_state == ADDR) & ~s_axi_lite_awvalid & s_axi_lite_arvalid;
			s_axi_lite_wready <= s_axi_lite_wready ? ~s_axi_lite_wvalid :
				((cfg_state == ADDR) & s_axi_lite_awvalid);
			s_axi_lite_bvalid <= s_axi_lite_bvalid ? ~s_axi_lite_bready :
				(s_axi_lite_wvalid & s_axi_lite_wready);
			s_axi_lite_rvalid <= s_axi_lite_rvalid ? ~s_axi_lite_rready : rd_en;
			if ((cfg_state == ADDR) & (s_axi_lite_awvalid | s_axi_lite_arvalid))
				is_write <= s_axi_lite_awvalid;
		end
	end

	always_ff @(posedge clk)
	begin
		if ((cfg_state == ADDR) & (s_axi_lite_awvalid | s_axi_lite_arvalid))
			ofs <= s_axi_lite_awvalid ? s_axi_lite_awaddr[2 +: `UPS_REG_AW] :
				s_axi_lite_araddr[2 +: `UPS_REG_AW];
	end

	always_comb
	begin
		case (ofs)
			4'd0: rd_mux = {22'd0, s2mm_idle_r, mm2s_idle_r, 8'd0};
			4'd1, 4'd2, 4'd3, 4'd4: rd_mux = buf_word[ofs[1:0] - 2'd1];
			4'd5: rd_mux = {22'd0, itr_en_vec, 7'd0, glb_en};
			4'd6: rd_mux = {22'd0, cause, 7'd0, glb_flag};
			4'd7: rd_mux = dim_word;
			4'd8: rd_mux = {16'd0, h_reg};
			default: rd_mux = '0; // unmapped offsets read zero
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rd_en)
			s_axi_lite_rdata <= rd_mux;
		{s2mm_idle_r, mm2s_idle_r} <= {dma_s2mm_idle, dma_mm2s_idle};
	end

	// start bits are one-shot
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			{dma_s2mm_start, dma_mm2s_start} <= 2'b00;
		else
			{dma_s2mm_start, dma_mm2s_start} <=
				{2{wr_en & s_axi_lite_wstrb[0] & (ofs == 4'd0)}} & s_axi_lite_wdata[1:0];
	end

	// buffer descriptors and frame dimensions
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (wr_en & (ofs == reg_ofs_t'(i + 1)))
				buf_word[i] <= strb_merge(buf_word[i], s_axi_lite_wdata, s_axi_lite_wstrb);
		end
		if (wr_en & (ofs == 4'd7))
			dim_word <= strb_merge(dim_word, s_axi_lite_wdata, s_axi_lite_wstrb);
		if (wr_en & (ofs == 4'd8) & s_axi_lite_wstrb[0])
			h_reg[7:0] <= s_axi_lite_wdata[7:0];
		if (wr_en & (ofs == 4'd8) & s_axi_lite_wstrb[1])
			h_reg[15:8] <= s_axi_lite_wdata[15:8];
	end

	assign in_ft_map_buf_baseaddr = buf_word[0];
	assign in_ft_map_buf_len = buf_word[1];
	assign out_ft_map_buf_baseaddr = buf_word[2];
	assign out_ft_map_buf_len = buf_word[3];
	assign feature_map_chn_n = dim_word[15:0];
	assign feature_map_w = dim_word[31:16];
	assign feature_map_h = h_reg;

	assign hit_vec = {dma_s2mm_done, dma_mm2s_done} & itr_en_vec;
	assign itr_req_now = (|hit_vec) & glb_en & ~glb_flag;
	assign flag_clr = wr_en & s_axi_lite_wstrb[0] & (ofs == 4'd6); // any byte-0 write

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			glb_en <= 1'b0;
			itr_en_vec <= 2'b00;
			glb_flag <= 1'b0;
			cause <= 2'b00;
			itr_req <= 1'b0;
		end
		else
		begin
			if (wr_en & s_axi_lite_wstrb[0] & (ofs == 4'd5))
				glb_en <= s_axi_lite_wdata[0];
			if (wr_en & s_axi_lite_wstrb[1] & (ofs == 4'd5))
				itr_en_vec <= s_axi_lite_wdata[9:8];
			if (flag_clr)
				glb_flag <= 1'b0;
			else if (itr_req_now)
				glb_flag <= 1'b1;
			if (itr_req_now)
				cause <= hit_vec;
			itr_req <= itr_req_now; // one cycle per accepted done
		end
	end

endmodule

`default_nettype wire

// ==== logic/itr_pulse_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "upsample_consts.svh"

module itr_pulse_gen (
	input wire clk,
	input wire rst_n,
	input wire itr_req,
	output logic itr
);

	localparam int CNT_W = $clog2(`UPS_ITR_PULSE_W + 1);

	logic [CNT_W-1:0] cnt; // cycles left in the pulse

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cnt <= '0;
		else if (cnt != '0)
			cnt <= cnt - 1'b1;
		else if (itr_req)
			cnt <= CNT_W'(`UPS_ITR_PULSE_W); // requests during a pulse are dropped
	end

	// high for exactly UPS_ITR_PULSE_W cycles
	assign itr = (cnt != '0);

endmodule

`default_nettype wire

// ==== logic/upsample_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "upsample_consts.svh"

module upsample_ctrl (
	input wire clk,
	input wire rst_n,
	input wire start,
	input wire upsample_pkg::dim_t chn_n,
	input wire upsample_pkg::dim_t w,
	input wire upsample_pkg::dim_t h,
	input wire in_avail,
	input wire out_avail,
	output logic load_en,
	output upsample_pkg::col_t load_col,
	output logic emit_en,
	output upsample_pkg::col_t emit_col,
	output logic busy
);
	import upsample_pkg::*;

	ups_state_t state;
	col_t col;
	dim_t row;
	dim_t chn;
	logic rep; // second copy of the pixel
	logic pass; // second copy of the row
	logic last_col;

	assign last_col = (col == w[`UPS_COL_W-1:0]);
	assign load_en = (state == LOAD) & in_avail;
	assign emit_en = (state == EMIT) & out_avail;
	assign load_col = col;
	assign emit_col = col;
	assign busy = (state != IDLE);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			col <= '0;
			row <= '0;
			chn <= '0;
			rep <= 1'b0;
			pass <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state <= LOAD;
						col <= '0;
						row <= '0;
						chn <= '0;
					end
				end
				LOAD:
				begin
					if (in_avail)
					begin
						if (last_col)
						begin
							state <= EMIT;
							col <= '0;
							rep <= 1'b0;
							pass <= 1'b0;
						end
						else
							col <= col + 1'b1;
					end
				end
				EMIT:
				begin
					if (out_avail)
					begin
						rep <= ~rep;
						if (rep & last_col)
						begin
							col <= '0;
							pass <= 1'b1;
							if (pass)
								state <= NEXT; // both rows sent
						end
						else if (rep)
							col <= col + 1'b1;
					end
				end
				NEXT:
				begin
					col <= '0;
					state <= LOAD;
					if (row != h)
						row <= row + 1'b1;
					else
					begin
						row <= '0;
						chn <= chn + 1'b1;
						if (chn == chn_n)
							state <= IDLE; // frame done
					end
				end
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/upsample_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "upsample_consts.svh"

module upsample_core (
	input wire clk,
	input wire rst_n,
	input wire in_valid,
	input wire upsample_pkg::pix_t in_data,
	output logic in_credit,
	input wire load_en,
	input wire upsample_pkg::col_t load_col,
	input wire emit_en,
	input wire upsample_pkg::col_t emit_col,
	output logic in_avail,
	output logic out_avail,
	output logic out_valid,
	output upsample_pkg::pix_t out_data,
	input wire out_credit
);
	import upsample_pkg::*;

	localparam int IN_PTR_W = $clog2(`UPS_IN_CREDITS);
	localparam int IN_CNT_W = $clog2(`UPS_IN_CREDITS + 1);
	localparam int OUT_CNT_W = $clog2(`UPS_OUT_CREDITS + 1);

	pix_t fifo_mem [`UPS_IN_CREDITS];
	logic [IN_PTR_W-1:0] wr_ptr;
	logic [IN_PTR_W-1:0] rd_ptr;
	logic [IN_CNT_W-1:0] fifo_cnt;

	pix_t row_buf [`UPS_MAX_W];
	logic [OUT_CNT_W-1:0] out_cred;

	// input fifo, sender credits keep it from overflowing
	always_ff @(posedge clk)
	begin
		if (in_valid)
			fifo_mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
			in_credit <= 1'b0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (load_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({in_valid, load_en})
				2'b10: fifo_cnt <= fifo_cnt + 1'b1;
				2'b01: fifo_cnt <= fifo_cnt - 1'b1;
				default: fifo_cnt <= fifo_cnt;
			endcase
			in_credit <= load_en; // one credit back per pop
		end
	end

	assign in_avail = (fifo_cnt != '0);

	// row buffer
	always_ff @(posedge clk)
	begin
		if (load_en)
			row_buf[load_col] <= fifo_mem[rd_ptr];
		if (emit_en)
			out_data <= row_buf[emit_col];
	end

	// credit spent when the beat is issued, so in-flight beats are covered
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			out_cred <= OUT_CNT_W'(`UPS_OUT_CREDITS);
		end
		else
		begin
			out_valid <= emit_en;
			case ({emit_en, out_credit})
				2'b10: out_cred <= out_cred - 1'b1;
				2'b01: out_cred <= out_cred + 1'b1;
				default: out_cred <= out_cred;
			endcase
		end
	end

	assign out_avail = (out_cred != '0);

endmodule

`default_nettype wire

// ==== logic/upsample_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module upsample_top (
	input wire clk,
	input wire rst_n,
	input wire upsample_pkg::word_t s_axi_lite_araddr,
	input wire [2:0] s_axi_lite_arprot,
	input wire s_axi_lite_arvalid,
	output logic s_axi_lite_arready,
	input wire upsample_pkg::word_t s_axi_lite_awaddr,
	input wire [2:0] s_axi_lite_awprot,
	input wire s_axi_lite_awvalid,
	output logic s_axi_lite_awready,
	output logic [1:0] s_axi_lite_bresp,
	output logic s_axi_lite_bvalid,
	input wire s_axi_lite_bready,
	output upsample_pkg::word_t s_axi_lite_rdata,
	output logic [1:0] s_axi_lite_rresp,
	output logic s_axi_lite_rvalid,
	input wire s_axi_lite_rready,
	input wire upsample_pkg::word_t s_axi_lite_wdata,
	input wire [3:0] s_axi_lite_wstrb,
	input wire s_axi_lite_wvalid,
	output logic s_axi_lite_wready,
	output logic dma_mm2s_start,
	output logic dma_s2mm_start,
	input wire dma_mm2s_idle,
	input wire dma_s2mm_idle,
	input wire dma_mm2s_done,
	input wire dma_s2mm_done,
	output upsample_pkg::word_t in_ft_map_buf_baseaddr,
	output upsample_pkg::word_t in_ft_map_buf_len,
	output upsample_pkg::word_t out_ft_map_buf_baseaddr,
	output upsample_pkg::word_t out_ft_map_buf_len,
	output logic itr,
	input wire in_valid,
	input wire upsample_pkg::pix_t in_data,
	output logic in_credit,
	output logic out_valid,
	output upsample_pkg::pix_t out_data,
	input wire out_credit
);
	import upsample_pkg::*;

	dim_t chn_n;
	dim_t fm_w;
	dim_t fm_h;
	logic itr_req;
	logic load_en;
	col_t load_col;
	logic emit_en;
	col_t emit_col;
	logic in_avail;
	logic out_avail;

	upsample_reg_if reg_if_inst (
		.clk(clk),
		.rst_n(rst_n),
		.s_axi_lite_araddr(s_axi_lite_araddr),
		.s_axi_lite_arprot(s_axi_lite_arprot),
		.s_axi_lite_arvalid(s_axi_lite_arvalid),
		.s_axi_lite_arready(s_axi_lite_arready),
		.s_axi_lite_awaddr(s_axi_lite_awaddr),
		.s_axi_lite_awprot(s_axi_lite_awprot),
		.s_axi_lite_awvalid(s_axi_lite_awvalid),
		.s_axi_lite_awready(s_axi_lite_awready),
		.s_axi_lite_bresp(s_axi_lite_bresp),
		.s_axi_lite_bvalid(s_axi_lite_bvalid),
		.s_axi_lite_bready(s_axi_lite_bready),
		.s_axi_lite_rdata(s_axi_lite_rdata),
		.s_axi_lite_rresp(s_axi_lite_rresp),
		.s_axi_lite_rvalid(s_axi_lite_rvalid),
		.s_axi_lite_rready(s_axi_lite_rready),
		.s_axi_lite_wdata(s_axi_lite_wdata),
		.s_axi_lite_wstrb(s_axi_lite_wstrb),
		.s_axi_lite_wvalid(s_axi_lite_wvalid),
		.s_axi_lite_wready(s_axi_lite_wready),
		.dma_mm2s_start(dma_mm2s_start),
		.dma_s2mm_start(dma_s2mm_start),
		.dma_mm2s_idle(dma_mm2s_idle),
		.dma_s2mm_idle(dma_s2mm_idle),
		.dma_mm2s_done(dma_mm2s_done),
		.dma_s2mm_done(dma_s2mm_done),
		.in_ft_map_buf_baseaddr(in_ft_map_buf_baseaddr),
		.in_ft_map_buf_len(in_ft_map_buf_len),
		.out_ft_map_buf_baseaddr(out_ft_map_buf_baseaddr),
		.out_ft_map_buf_len(out_ft_map_buf_len),
		.feature_map_chn_n(chn_n),
		.feature_map_w(fm_w),
		.feature_map_h(fm_h),
		.itr_req(itr_req)
	);

	itr_pulse_gen itr_pulse_gen_inst (
		.clk(clk),
		.rst_n(rst_n),
		.itr_req(itr_req),
		.itr(itr)
	);

	// a frame runs alongside the s2mm transfer
	upsample_ctrl ctrl_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(dma_s2mm_start),
		.chn_n(chn_n),
		.w(fm_w),
		.h(fm_h),
		.in_avail(in_avail),
		.out_avail(out_avail),
		.load_en(load_en),
		.load_col(load_col),
		.emit_en(emit_en),
		.emit_col(emit_col),
		.busy()
	);

	upsample_core core_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_credit(in_credit),
		.load_en(load_en),
		.load_col(load_col),
		.emit_en(emit_en),
		.emit_col(emit_col),
		.in_avail(in_avail),
		.out_avail(out_avail),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_credit(out_credit)
	);

endmodule

`default_nettype wire

// ==== tests/upsample_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "upsample_consts.svh"

module upsample_tb;
	import upsample_pkg::*;

	localparam int MAX_OUT = 4 * 8 * 4 * 4; // largest random frame in output pixels
	localparam int FRAME_CYC = 8 * MAX_OUT;
	localparam int TEST_CYC = 16 + 3 * FRAME_CYC + 40 * 10 + 4 * (`UPS_ITR_PULSE_W + 20);
	localparam int TIMEOUT_CYC = 2 * TEST_CYC;

	logic clk;
	logic rst_n;
	word_t s_axi_lite_araddr;
	logic [2:0] s_axi_lite_arprot;
	logic s_axi_lite_arvalid;
	logic s_axi_lite_arready;
	word_t s_axi_lite_awaddr;
	logic [2:0] s_axi_lite_awprot;
	logic s_axi_lite_awvalid;
	logic s_axi_lite_awready;
	logic [1:0] s_axi_lite_bresp;
	logic s_axi_lite_bvalid;
	logic s_axi_lite_bready;
	word_t s_axi_lite_rdata;
	logic [1:0] s_axi_lite_rresp;
	logic s_axi_lite_rvalid;
	logic s_axi_lite_rready;
	word_t s_axi_lite_wdata;
	logic [3:0] s_axi_lite_wstrb;
	logic s_axi_lite_wvalid;
	logic s_axi_lite_wready;
	logic dma_mm2s_start;
	logic dma_s2mm_start;
	logic dma_mm2s_idle;
	logic dma_s2mm_idle;
	logic dma_mm2s_done;
	logic dma_s2mm_done;
	word_t in_ft_map_buf_baseaddr;
	word_t in_ft_map_buf_len;
	word_t out_ft_map_buf_baseaddr;
	word_t out_ft_map_buf_len;
	logic itr;
	logic in_valid;
	pix_t in_data;
	logic in_credit;
	logic out_valid;
	pix_t out_data;
	logic out_credit;

	integer seed = 62575;
	int errors = 0;
	int checks = 0;
	int cycles;
	int mm2s_starts = 0;
	int s2mm_starts = 0;
	int out_beats = 0;
	int out_held; // credits the core may still spend as seen by the receiver
	int in_held; // credits the sender may still spend
	pix_t exp_q[$];
	word_t exp_reg [`UPS_REGS_N];
	int rw_ofs [7] = '{1, 2, 3, 4, 5, 7, 8};

	upsample_top upsample_top_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (dma_mm2s_start)
			mm2s_starts++;
		if (dma_s2mm_start)
			s2mm_starts++;
		if (out_valid)
			out_beats++;
	end

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_held <= `UPS_OUT_CREDITS;
			in_held <= `UPS_IN_CREDITS;
		end
		else
		begin
			out_held <= out_held + int'(out_credit) - int'(out_valid);
			in_held <= in_held + int'(in_credit) - int'(in_valid);
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> out_held > 0)
	else
	begin
		$display("out_valid beat sent while no output credit was held");
		errors++;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		in_credit |-> in_held < `UPS_IN_CREDITS)
	else
	begin
		$display("in_credit returned while the sender already held all its credits");
		errors++;
	end

	task automatic check_value(input string name, input word_t exp, input word_t act);
		checks++;
		assert (act === exp)
		else
		begin
			$display("** Error: %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		if (errors == err_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_start);
	endtask

	function automatic word_t field_mask(input int ofs);
		case (ofs)
			5: return 32'h0000_0301; // global, mm2s and s2mm enables
			8: return 32'h0000_ffff;
			default: return 32'hffff_ffff;
		endcase
	endfunction

	function automatic word_t apply_strobes(input word_t old_v, input word_t new_v,
		input logic [3:0] strb);
		word_t m;
		m = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_v & ~m) | (new_v & m);
	endfunction

	task automatic axi_write(input word_t addr, input word_t data, input logic [3:0] strb);
		logic aw_done;
		logic w_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		s_axi_lite_awaddr <= addr;
		s_axi_lite_awvalid <= 1'b1;
		s_axi_lite_wdata <= data;
		s_axi_lite_wstrb <= strb;
		s_axi_lite_wvalid <= 1'b1;
		while (!(aw_done && w_done))
		begin
			@(posedge clk);
			if (s_axi_lite_awready && !aw_done)
			begin
				s_axi_lite_awvalid <= 1'b0;
				aw_done = 1'b1;
			end
			if (s_axi_lite_wready && !w_done)
			begin
				s_axi_lite_wvalid <= 1'b0;
				w_done = 1'b1;
			end
		end
		do @(posedge clk); while (!s_axi_lite_bvalid); // bready is held high
		check_value("s_axi_lite_bresp", 2'b00, s_axi_lite_bresp);
	endtask

	task automatic axi_read(input word_t addr, output word_t data);
		s_axi_lite_araddr <= addr;
		s_axi_lite_arvalid <= 1'b1;
		do @(posedge clk); while (!s_axi_lite_arready);
		s_axi_lite_arvalid <= 1'b0;
		do @(posedge clk); while (!s_axi_lite_rvalid);
		data = s_axi_lite_rdata;
		check_value("s_axi_lite_rresp", 2'b00, s_axi_lite_rresp);
	endtask

	// mm2s model sending random pixels within the credits it holds
	task automatic mm2s_send(input int w1, input int total);
		int cred;
		int sent;
		int p;
		pix_t px;
		pix_t row_px[$];
		cred = `UPS_IN_CREDITS;
		sent = 0;
		do @(posedge clk); while (!dma_mm2s_start);
		dma_mm2s_idle <= 1'b0;
		while (sent < total)
		begin
			@(posedge clk);
			if (in_credit)
				cred++;
			if (cred > 0 && ($random(seed) & 1))
			begin
				px = pix_t'($random(seed));
				in_valid <= 1'b1;
				in_data <= px;
				cred--;
				sent++;
				row_px.push_back(px);
				if (row_px.size() == w1)
				begin
					// each row twice and each pixel twice within the row
					for (p = 0; p < 2; p++)
						foreach (row_px[k])
						begin
							exp_q.push_back(row_px[k]);
							exp_q.push_back(row_px[k]);
						end
					row_px.delete();
				end
			end
			else
				in_valid <= 1'b0;
		end
		@(posedge clk);
		in_valid <= 1'b0;
		dma_mm2s_done <= 1'b1;
		@(posedge clk);
		dma_mm2s_done <= 1'b0;
		dma_mm2s_idle <= 1'b1;
	endtask

	// s2mm model returning credits after random delays
	task automatic s2mm_collect(input int total, input int stall);
		int got;
		int owed;
		int stall_beats;
		got = 0;
		owed = 0;
		stall_beats = 0;
		do @(posedge clk); while (!dma_s2mm_start);
		dma_s2mm_idle <= 1'b0;
		while (got < total || owed > 0)
		begin
			@(posedge clk);
			if (out_valid)
			begin
				if (exp_q.size() == 0)
				begin
					$display("output beat arrived with no pixel left to expect");
					errors++;
				end
				else
					check_value("out_data", exp_q.pop_front(), out_data);
				got++;
				owed++;
				if (stall > 0)
					stall_beats++;
			end
			if (stall > 0)
			begin
				stall--;
				out_credit <= 1'b0;
			end
			else if (owed > 0 && ($random(seed) & 3) != 0)
			begin
				out_credit <= 1'b1;
				owed--;
			end
			else
				out_credit <= 1'b0;
		end
		@(posedge clk);
		out_credit <= 1'b0;
		dma_s2mm_done <= 1'b1;
		@(posedge clk);
		dma_s2mm_done <= 1'b0;
		dma_s2mm_idle <= 1'b1;
		assert (stall_beats <= `UPS_OUT_CREDITS)
		else
		begin
			$display("%0d beats arrived while credits were withheld", stall_beats);
			errors++;
		end
	endtask

	task automatic run_frame(input int c, input int w, input int h, input int stall);
		int n_in;
		int mm2s_before;
		int s2mm_before;
		int beats_before;
		word_t rd;
		n_in = (w + 1) * (h + 1) * (c + 1);
		axi_write(32'h1c, {16'(w), 16'(c)}, 4'hf);
		axi_write(32'h20, word_t'(h), 4'hf);
		mm2s_before = mm2s_starts;
		s2mm_before = s2mm_starts;
		beats_before = out_beats;
		fork
			mm2s_send(w + 1, n_in);
			s2mm_collect(4 * n_in, stall);
			axi_write(32'h00, 32'h3, 4'hf);
		join
		axi_read(32'h00, rd);
		check_value("ctrl idle bits", 32'h300, rd);
		check_value("dma_mm2s_start cycles", 1, mm2s_starts - mm2s_before);
		check_value("dma_s2mm_start cycles", 1, s2mm_starts - s2mm_before);
		check_value("out_valid beats", 4 * n_in, out_beats - beats_before);
		check_value("pixels still expected", 0, exp_q.size());
		check_value("busy", 0, upsample_top_inst.ctrl_inst.busy);
	endtask

	// done pulse on s2mm followed by a sample-by-sample watch of itr
	task automatic done_and_watch(input logic expect_pulse);
		int i;
		dma_s2mm_done <= 1'b1;
		@(posedge clk);
		dma_s2mm_done <= 1'b0;
		for (i = 1; i <= `UPS_ITR_PULSE_W + 4; i++)
		begin
			@(posedge clk);
			check_value("itr", expect_pulse && i >= 2 && i < 2 + `UPS_ITR_PULSE_W, itr);
		end
	endtask

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYC)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, run did not finish within %0d cycles", TIMEOUT_CYC);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		word_t rd;
		word_t data;
		logic [3:0] strb;
		logic wr_flag;
		int i;
		int e0;
		rst_n = 1'b0;
		s_axi_lite_araddr = '0;
		s_axi_lite_arprot = 3'b000;
		s_axi_lite_arvalid = 1'b0;
		s_axi_lite_awaddr = '0;
		s_axi_lite_awprot = 3'b000;
		s_axi_lite_awvalid = 1'b0;
		s_axi_lite_bready = 1'b1;
		s_axi_lite_rready = 1'b1;
		s_axi_lite_wdata = '0;
		s_axi_lite_wstrb = 4'h0;
		s_axi_lite_wvalid = 1'b0;
		dma_mm2s_idle = 1'b1;
		dma_s2mm_idle = 1'b1;
		dma_mm2s_done = 1'b0;
		dma_s2mm_done = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		out_credit = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		e0 = errors;
		for (i = 0; i < 7; i++)
		begin
			data = $random(seed);
			axi_write(word_t'(rw_ofs[i] * 4), data, 4'hf);
			exp_reg[rw_ofs[i]] = data & field_mask(rw_ofs[i]);
		end
		for (i = 0; i < 7; i++)
		begin
			data = $random(seed);
			strb = 4'($random(seed));
			axi_write(word_t'(rw_ofs[i] * 4), data, strb);
			exp_reg[rw_ofs[i]] = apply_strobes(exp_reg[rw_ofs[i]], data, strb) &
				field_mask(rw_ofs[i]);
			axi_read(word_t'(rw_ofs[i] * 4), rd);
			check_value("s_axi_lite_rdata", exp_reg[rw_ofs[i]], rd);
		end
		check_value("in_ft_map_buf_baseaddr", exp_reg[1], in_ft_map_buf_baseaddr);
		check_value("in_ft_map_buf_len", exp_reg[2], in_ft_map_buf_len);
		check_value("out_ft_map_buf_baseaddr", exp_reg[3], out_ft_map_buf_baseaddr);
		check_value("out_ft_map_buf_len", exp_reg[4], out_ft_map_buf_len);
		check_value("feature_map_chn_n", exp_reg[7][15:0], upsample_top_inst.chn_n);
		check_value("feature_map_w", exp_reg[7][31:16], upsample_top_inst.fm_w);
		check_value("feature_map_h", exp_reg[8][15:0], upsample_top_inst.fm_h);
		axi_read(32'h24, rd); // past the map
		check_value("unmapped rdata", 0, rd);
		axi_write(32'h14, 32'h0, 4'hf);
		report_test("register readback", e0);

		e0 = errors;
		dma_s2mm_idle <= 1'b0;
		axi_read(32'h00, rd);
		check_value("ctrl idle bits", 32'h100, rd);
		dma_mm2s_idle <= 1'b0;
		dma_s2mm_idle <= 1'b1;
		axi_read(32'h00, rd);
		check_value("ctrl idle bits", 32'h200, rd);
		dma_mm2s_idle <= 1'b1;
		run_frame(0, 0, 0, 0); // one pixel giving four outputs
		report_test("control word", e0);

		e0 = errors;
		run_frame($random(seed) & 3, $random(seed) & 7, $random(seed) & 3, 0);
		report_test("upsampling", e0);

		e0 = errors;
		run_frame($random(seed) & 3, $random(seed) & 7, $random(seed) & 3, 40);
		report_test("credit back-pressure", e0);

		e0 = errors;
		axi_write(32'h14, 32'h201, 4'hf); // global and s2mm done
		axi_write(32'h18, 32'h1, 4'hf);
		done_and_watch(1'b1);
		axi_read(32'h18, rd);
		check_value("itr flags", 32'h201, rd);
		done_and_watch(1'b0); // flag still set
		axi_write(32'h18, 32'h1, 4'hf);
		axi_read(32'h18, rd);
		check_value("itr global flag", 0, rd[0]);
		done_and_watch(1'b1);
		axi_write(32'h14, 32'h0, 4'hf);
		axi_write(32'h18, 32'h1, 4'hf);
		done_and_watch(1'b0);
		axi_read(32'h18, rd);
		check_value("itr flags", 32'h200, rd); // cause bits kept
		report_test("interrupts", e0);

		e0 = errors;
		data = $random(seed);
		wr_flag = 1'b0;
		fork
			begin
				axi_write(32'h10, data, 4'hf);
				wr_flag = 1'b1;
			end
			begin
				axi_read(32'h10, rd);
				assert (wr_flag)
				else
				begin
					$display("read finished before the competing write");
					errors++;
				end
			end
		join
		check_value("s_axi_lite_rdata", data, rd);
		report_test("write priority", e0);

		$display("6 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/upsample_pkg.sv
logic/upsample_reg_if.sv
logic/itr_pulse_gen.sv
logic/upsample_ctrl.sv
logic/upsample_core.sv
logic/upsample_top.sv
tests/upsample_tb.sv

// ==== Bender.yml ====
package:
  name: upsample

sources:
  - include_dirs:
      - logic
    files:
      - logic/upsample_pkg.sv
      - logic/upsample_reg_if.sv
      - logic/itr_pulse_gen.sv
      - logic/upsample_ctrl.sv
      - logic/upsample_core.sv
      - logic/upsample_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/upsample_tb.sv
